// ==== Makefile ====
# Verilator build and run for the reorder buffer testbench

TOP       ?= rob_tb
FILELIST  ?= rob_top.f
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FAIL_MSG := Test failures found
PASS_MSG := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: TOP FILELIST VERILATOR BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q '$(FAIL_MSG)' $(LOG); then \
	    echo "simulation reported errors, see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ] || ! grep -q '$(PASS_MSG)' $(LOG); then \
	    echo "simulation ended without a pass result, see $(LOG)"; exit 1; \
	fi; \
	echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/rob_complete_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_complete_tracker
    import rob_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire                       flush_i,
    input  rob_id_t [1:0]             alloc_id_i,
    input  wire     [1:0]             alloc_we_i,
    input  rob_id_t [1:0]             cdb_id_i,
    input  wire     [1:0]             cdb_we_i,
    input  rob_id_t [ROB_TRK_RD-1:0]  rd_id_i,
    output logic    [ROB_TRK_RD-1:0]  complete_o
);

    logic [ROB_DEPTH-1:0] disp_tgl_q;
    logic [ROB_DEPTH-1:0] disp_tgl_d;
    logic [ROB_DEPTH-1:0] cdb_tgl_q;
    logic [ROB_DEPTH-1:0] cdb_tgl_d;

    // each write flips its entry bit
    always_comb begin
        disp_tgl_d = disp_tgl_q;
        cdb_tgl_d  = cdb_tgl_q;
        for (int i = 0; i < 2; i++) begin
            if (alloc_we_i[i]) begin
                disp_tgl_d[alloc_id_i[i]] = ~disp_tgl_q[alloc_id_i[i]];
            end
            if (cdb_we_i[i]) begin
                cdb_tgl_d[cdb_id_i[i]] = ~cdb_tgl_q[cdb_id_i[i]];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            disp_tgl_q <= '0;
            cdb_tgl_q  <= '0;
        end else if (flush_i) begin
            disp_tgl_q <= '0;
            cdb_tgl_q  <= '0;
        end else begin
            disp_tgl_q <= disp_tgl_d;
            cdb_tgl_q  <= cdb_tgl_d;
        end
    end

    // tables agree once the result has caught up with the dispatch
    always_comb begin
        for (int k = 0; k < ROB_TRK_RD; k++) begin
            complete_o[k] = ~(disp_tgl_q[rd_id_i[k]] ^ cdb_tgl_q[rd_id_i[k]]);
        end
    end

endmodule

`default_nettype wire

// ==== design/rob_flush_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_flush_fsm
    import rob_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire       [1:0]        retire_valid_i,
    input  rob_ctrl_t [1:0]        retire_ctrl_i,
    input  wire       [1:0][XLEN-1:0] retire_pc_i,
    output flush_state_e           state_o,
    output logic                   flush_o,
    output logic      [XLEN-1:0]   redirect_pc_o
);

    flush_state_e    state_q;
    flush_state_e    state_d;
    logic [1:0]      fault;
    logic [XLEN-1:0] redirect_pc_q;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            fault[i] = retire_valid_i[i] &&
                       (retire_ctrl_i[i].exception || retire_ctrl_i[i].bpu_fail);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // run -> flush -> resume -> run
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RUN:    if (|fault) state_d = ST_FLUSH;
            ST_FLUSH:  state_d = ST_RESUME;
            ST_RESUME: state_d = ST_RUN;
            default:   state_d = ST_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // slot 1 never faults alongside slot 0, still prefer the older one
    always_ff @(posedge clk) begin
        if (state_q == ST_RUN && |fault) begin
            redirect_pc_q <= fault[0] ? retire_pc_i[0] : retire_pc_i[1];
        end
    end

    assign state_o       = state_q;
    assign flush_o       = (state_q == ST_FLUSH);
    assign redirect_pc_o = redirect_pc_q;

endmodule

`default_nettype wire

// ==== design/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int ROB_WIDTH  = 6;
    localparam int ROB_DEPTH  = 64;
    localparam int XLEN       = 32;
    localparam int AREG_WIDTH = 5;

    // occupancy counter has to reach ROB_DEPTH itself
    localparam int ROB_CNT_WIDTH = ROB_WIDTH + 1;

    // two tail reads plus two sources for each of the two dispatch slots
    localparam int ROB_TRK_RD = 6;

    typedef logic [ROB_WIDTH-1:0] rob_id_t;

    typedef enum logic [1:0] {
        TYPE_ALU    = 2'd0,
        TYPE_LOAD   = 2'd1,
        TYPE_STORE  = 2'd2,
        TYPE_BRANCH = 2'd3
    } inst_type_e;

    typedef enum logic [1:0] {
        ST_RUN    = 2'd0,
        ST_FLUSH  = 2'd1,
        ST_RESUME = 2'd2
    } flush_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // table entries
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic exception;
        logic bpu_fail;
    } rob_ctrl_t;

    // info table row, 41 bits
    typedef struct packed {
        inst_type_e            inst_type;
        logic [AREG_WIDTH-1:0] areg;
        logic [XLEN-1:0]       pc;
        logic                  w_reg;
        logic                  w_mem;
    } rob_inst_entry_t;

    // data table row, 34 bits
    typedef struct packed {
        logic [XLEN-1:0] data;
        rob_ctrl_t       ctrl;
    } rob_data_entry_t;

    ////////////////////////////////////////////////////////////////////////////
    // outside ports
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        inst_type_e            inst_type;
        logic [AREG_WIDTH-1:0] areg;
        logic [XLEN-1:0]       pc;
        logic                  w_reg;
        logic                  w_mem;
        rob_id_t [1:0]         src_id;
    } dispatch_rob_t;

    typedef struct packed {
        rob_id_t               rob_id;
        logic [1:0][XLEN-1:0]  src_data;
        logic [1:0]            src_ready;
    } rob_dispatch_t;

    typedef struct packed {
        logic            valid;
        rob_id_t         rob_id;
        logic [XLEN-1:0] data;
        rob_ctrl_t       ctrl;
    } cdb_rob_t;

    typedef struct packed {
        logic                  valid;
        logic [AREG_WIDTH-1:0] areg;
        logic                  w_reg;
        logic                  w_mem;
        logic [XLEN-1:0]       data;
        logic [XLEN-1:0]       pc;
    } rob_commit_t;

endpackage

`default_nettype wire

// ==== design/rob_ptr_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_ptr_ctrl
    import rob_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire                      flush_i,
    input  wire  [1:0]               alloc_cnt_i,
    input  wire  [1:0]               retire_cnt_i,
    output rob_id_t                  head_o,
    output rob_id_t                  tail_o,
    output logic [ROB_CNT_WIDTH-1:0] count_o,
    output logic                     two_free_o
);

    rob_id_t                  head_q;
    rob_id_t                  tail_q;
    logic [ROB_CNT_WIDTH-1:0] count_q;
    logic [ROB_CNT_WIDTH-1:0] count_d;
    logic                     two_free_q;

    assign count_d = count_q + ROB_CNT_WIDTH'(alloc_cnt_i) - ROB_CNT_WIDTH'(retire_cnt_i);

    ////////////////////////////////////////////////////////////////////////////
    // pointers, wrap modulo 64 for free
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + ROB_WIDTH'(alloc_cnt_i);
            tail_q  <= tail_q + ROB_WIDTH'(retire_cnt_i);
            count_q <= count_d;
        end
    end

    // room for a full dispatch pair next cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            two_free_q <= 1'b1;
        end else if (flush_i) begin
            two_free_q <= 1'b1;
        end else begin
            two_free_q <= (count_d <= ROB_CNT_WIDTH'(ROB_DEPTH - 2));
        end
    end

    assign head_o     = head_q;
    assign tail_o     = tail_q;
    assign count_o    = count_q;
    assign two_free_o = two_free_q;

endmodule

`default_nettype wire

// ==== design/rob_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_table
    import rob_pkg::*;
#(
    parameter int ENTRY_W = 34,
    parameter int RD_NUM  = 2
) (
    input  wire                               clk,
    input  wire                               rst_n_i,
    input  rob_id_t [RD_NUM-1:0]              raddr_i,
    input  rob_id_t [1:0]                     waddr_i,
    input  wire     [1:0]                     we_i,
    input  wire     [1:0][ENTRY_W-1:0]        wdata_i,
    output logic    [RD_NUM-1:0][ENTRY_W-1:0] rdata_o
);

    localparam int BANK_ROWS = ROB_DEPTH / 2;

    // per bank read data before the bank select
    logic [1:0][RD_NUM-1:0][ENTRY_W-1:0] bank_rd;

    ////////////////////////////////////////////////////////////////////////////
    // two banks split on the low index bit
    ////////////////////////////////////////////////////////////////////////////

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [ENTRY_W-1:0] rows [BANK_ROWS];

        // head and head+1 always land in different banks
        always_ff @(posedge clk) begin
            for (int w = 0; w < 2; w++) begin
                if (we_i[w] && rst_n_i && (waddr_i[w][0] == 1'(b))) begin
                    rows[waddr_i[w][ROB_WIDTH-1:1]] <= wdata_i[w];
                end
            end
        end

        for (genvar r = 0; r < RD_NUM; r++) begin : g_rd
            assign bank_rd[b][r] = rows[raddr_i[r][ROB_WIDTH-1:1]];
        end
    end

    // bank select on the low address bit
    always_comb begin
        for (int r = 0; r < RD_NUM; r++) begin
            rdata_o[r] = raddr_i[r][0] ? bank_rd[1][r] : bank_rd[0][r];
        end
    end

endmodule

`default_nettype wire

// ==== design/rob_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_top
    import rob_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n_i,
    input  dispatch_rob_t [1:0] dispatch_i,
    output logic                dispatch_ready_o,
    output rob_dispatch_t [1:0] rob_dispatch_o,
    input  cdb_rob_t      [1:0] cdb_i,
    output rob_commit_t   [1:0] commit_o,
    output logic                flush_o,
    output logic [XLEN-1:0]     redirect_pc_o
);

    flush_state_e                state;
    logic                        run;
    rob_id_t                     head;
    rob_id_t                     tail;
    logic [ROB_CNT_WIDTH-1:0]    count;
    logic                        two_free;
    rob_id_t [1:0]               alloc_id;
    logic [1:0]                  alloc_we;
    rob_id_t [1:0]               tail_id;
    rob_id_t [1:0]               cdb_id;
    logic [1:0]                  cdb_we;
    rob_inst_entry_t [1:0]       info_wr;
    rob_inst_entry_t [1:0]       info_rd;
    rob_data_entry_t [1:0]       data_wr;
    rob_data_entry_t [ROB_TRK_RD-1:0] data_rd;
    rob_id_t [ROB_TRK_RD-1:0]    rd_id;
    logic [ROB_TRK_RD-1:0]       complete;
    logic [1:0]                  commit_vld;
    logic [1:0]                  retire_cnt;
    rob_ctrl_t [1:0]             retire_ctrl;
    logic [1:0][XLEN-1:0]        retire_pc;

    assign run              = (state == ST_RUN);
    assign dispatch_ready_o = two_free && run;

    ////////////////////////////////////////////////////////////////////////////
    // allocation and source reads
    ////////////////////////////////////////////////////////////////////////////

    assign tail_id = {tail + ROB_WIDTH'(1), tail};

    // read order: tail, tail+1, then both sources of slot 0 and slot 1
    assign rd_id = {dispatch_i[1].src_id, dispatch_i[0].src_id, tail_id};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            alloc_id[i]           = head + ROB_WIDTH'(i);
            alloc_we[i]           = dispatch_i[i].valid && dispatch_ready_o;
            info_wr[i].inst_type  = dispatch_i[i].inst_type;
            info_wr[i].areg       = dispatch_i[i].areg;
            info_wr[i].pc         = dispatch_i[i].pc;
            info_wr[i].w_reg      = dispatch_i[i].w_reg;
            info_wr[i].w_mem      = dispatch_i[i].w_mem;
            // results for flushed entries are dropped
            cdb_id[i]             = cdb_i[i].rob_id;
            cdb_we[i]             = cdb_i[i].valid && run;
            data_wr[i].data       = cdb_i[i].data;
            data_wr[i].ctrl       = cdb_i[i].ctrl;
            rob_dispatch_o[i].rob_id = alloc_id[i];
            for (int k = 0; k < 2; k++) begin
                rob_dispatch_o[i].src_data[k]  = data_rd[2 + 2*i + k].data;
                rob_dispatch_o[i].src_ready[k] = complete[2 + 2*i + k];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // retirement select
    ////////////////////////////////////////////////////////////////////////////

    // a flagged slot 0 ends the retire group
    assign commit_vld[0] = run && (count != '0) && complete[0];
    assign commit_vld[1] = commit_vld[0] && (count >= ROB_CNT_WIDTH'(2)) && complete[1] &&
                           !(data_rd[0].ctrl.exception || data_rd[0].ctrl.bpu_fail);
    assign retire_cnt    = 2'(commit_vld[0]) + 2'(commit_vld[1]);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            commit_o[i].valid = commit_vld[i];
            commit_o[i].areg  = info_rd[i].areg;
            commit_o[i].w_reg = info_rd[i].w_reg;
            commit_o[i].w_mem = info_rd[i].w_mem;
            commit_o[i].data  = data_rd[i].data;
            commit_o[i].pc    = info_rd[i].pc;
            retire_ctrl[i]    = data_rd[i].ctrl;
            retire_pc[i]      = info_rd[i].pc;
        end
    end

    rob_table #(
        .ENTRY_W ($bits(rob_inst_entry_t)),
        .RD_NUM  (2)
    ) info_table (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .raddr_i (tail_id),
        .waddr_i (alloc_id),
        .we_i    (alloc_we),
        .wdata_i (info_wr),
        .rdata_o (info_rd)
    );

    rob_table #(
        .ENTRY_W ($bits(rob_data_entry_t)),
        .RD_NUM  (ROB_TRK_RD)
    ) data_table (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .raddr_i (rd_id),
        .waddr_i (cdb_id),
        .we_i    (cdb_we),
        .wdata_i (data_wr),
        .rdata_o (data_rd)
    );

    rob_complete_tracker i_tracker (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_o),
        .alloc_id_i (alloc_id),
        .alloc_we_i (alloc_we),
        .cdb_id_i   (cdb_id),
        .cdb_we_i   (cdb_we),
        .rd_id_i    (rd_id),
        .complete_o (complete)
    );

    rob_ptr_ctrl i_ptr_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_o),
        .alloc_cnt_i  (2'(alloc_we[0]) + 2'(alloc_we[1])),
        .retire_cnt_i (retire_cnt),
        .head_o       (head),
        .tail_o       (tail),
        .count_o      (count),
        .two_free_o   (two_free)
    );

    rob_flush_fsm i_flush_fsm (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .retire_valid_i (commit_vld),
        .retire_ctrl_i  (retire_ctrl),
        .retire_pc_i    (retire_pc),
        .state_o        (state),
        .flush_o        (flush_o),
        .redirect_pc_o  (redirect_pc_o)
    );

endmodule

`default_nettype wire

// ==== rob_top.f ====
design/rob_pkg.sv
design/rob_table.sv
design/rob_complete_tracker.sv
design/rob_ptr_ctrl.sv
design/rob_flush_fsm.sv
design/rob_top.sv
testbench/rob_assert.sv
testbench/rob_tb.sv

// ==== testbench/rob_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_assert
    import rob_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire                      flush_i,
    input  wire                      dispatch_ready_i,
    input  rob_commit_t [1:0]        commit_i,
    input  rob_ctrl_t   [1:0]        retire_ctrl_i,
    input  flush_state_e             state_i,
    input  wire [ROB_CNT_WIDTH-1:0]  count_i
);

    ////////////////////////////////////////////////////////////////////////////
    // flush sequencing
    ////////////////////////////////////////////////////////////////////////////

    // one cycle pulse that leaves the buffer empty
    a_flush_pulse : assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> (!flush_i && (count_i == '0)))
        else $error("flush_o longer than one cycle or buffer not emptied");

    // registered ready has to track the occupancy counter
    a_ready_run : assert property (@(posedge clk) disable iff (!rst_n_i)
        dispatch_ready_i |-> ((state_i == ST_RUN) &&
                              (count_i <= ROB_CNT_WIDTH'(ROB_DEPTH - 2))))
        else $error("dispatch_ready_o high outside ST_RUN or without two free entries");

    ////////////////////////////////////////////////////////////////////////////
    // retirement and occupancy
    ////////////////////////////////////////////////////////////////////////////

    // a flagged retirement starts the flush in the next cycle
    a_fault_flush : assert property (@(posedge clk) disable iff (!rst_n_i)
        ((commit_i[0].valid &&
          (retire_ctrl_i[0].exception || retire_ctrl_i[0].bpu_fail)) ||
         (commit_i[1].valid &&
          (retire_ctrl_i[1].exception || retire_ctrl_i[1].bpu_fail))) |=> flush_i)
        else $error("flagged retirement not followed by flush_o");

    a_count_max : assert property (@(posedge clk) disable iff (!rst_n_i)
        count_i <= ROB_CNT_WIDTH'(ROB_DEPTH))
        else $error("occupancy count above the buffer depth");

endmodule

`default_nettype wire

// ==== testbench/rob_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_tb
    import rob_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RESET_CYCLES   = 16;

    logic                  clk = 1'b0;
    logic                  rst_n;
    dispatch_rob_t [1:0]   dispatch;
    rob_dispatch_t [1:0]   disp_reply;
    cdb_rob_t      [1:0]   cdb;
    rob_commit_t   [1:0]   commit;
    logic                  dispatch_ready;
    logic                  flush;
    logic [XLEN-1:0]       redirect_pc;

    // expected buffer contents
    rob_id_t               exp_head;
    rob_id_t               exp_tail;
    logic [XLEN-1:0]       exp_pc    [ROB_DEPTH];
    logic [AREG_WIDTH-1:0] exp_areg  [ROB_DEPTH];
    logic [XLEN-1:0]       exp_data  [ROB_DEPTH];
    logic                  exp_w_reg [ROB_DEPTH];
    logic                  exp_w_mem [ROB_DEPTH];

    integer                seed;
    int                    err_cnt = 0;
    int                    check_cnt = 0;
    int                    test_cnt = 0;
    int                    test_err_start = 0;
    int                    cycle_cnt = 0;

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    rob_top i_dut (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .dispatch_i       (dispatch),
        .dispatch_ready_o (dispatch_ready),
        .rob_dispatch_o   (disp_reply),
        .cdb_i            (cdb),
        .commit_o         (commit),
        .flush_o          (flush),
        .redirect_pc_o    (redirect_pc)
    );

    bind rob_top rob_assert i_rob_assert (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_o),
        .dispatch_ready_i (dispatch_ready_o),
        .commit_i         (commit_o),
        .retire_ctrl_i    (retire_ctrl),
        .state_i          (state),
        .count_i          (count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual, input string what);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("mismatch at %0t: %s, expected 0x%0h, got 0x%0h",
                     $time, what, expected, actual);
        end
    endtask

    // next edge plus the drive delay
    task automatic next_edge();
        @(posedge clk);
        #2;
    endtask

    task automatic start_test();
        test_cnt++;
        test_err_start = err_cnt;
    endtask

    task automatic end_test(input string name);
        $display("test %0d (%s) done, %0d errors", test_cnt, name, err_cnt - test_err_start);
    endtask

    // both slots valid with ids from the expected head
    task automatic dispatch_pair(input logic [XLEN-1:0] pc_base);
        rob_id_t id;
        for (int i = 0; i < 2; i++) begin
            id = exp_head + ROB_WIDTH'(i);
            exp_pc[id]            = pc_base + {24'h0, id, 2'b00};
            exp_areg[id]          = AREG_WIDTH'(id) + 5'd3;
            exp_w_mem[id]         = id[0] ^ id[1];
            exp_w_reg[id]         = !exp_w_mem[id];
            dispatch[i].valid     = 1'b1;
            dispatch[i].inst_type = exp_w_mem[id] ? TYPE_STORE : TYPE_ALU;
            dispatch[i].areg      = exp_areg[id];
            dispatch[i].pc        = exp_pc[id];
            dispatch[i].w_reg     = exp_w_reg[id];
            dispatch[i].w_mem     = exp_w_mem[id];
        end
        @(negedge clk);
        check_value(32'h1, 32'(dispatch_ready), "dispatch_ready_o at dispatch");
        for (int i = 0; i < 2; i++) begin
            id = exp_head + ROB_WIDTH'(i);
            check_value(32'(id), 32'(disp_reply[i].rob_id), $sformatf("slot %0d rob_id", i));
        end
        next_edge();
        dispatch[0].valid = 1'b0;
        dispatch[1].valid = 1'b0;
        exp_head = exp_head + ROB_WIDTH'(2);
    endtask

    // port 1 only carries a result when both is set
    task automatic write_results(input rob_id_t id0, input rob_ctrl_t ctrl0,
                                 input logic both, input rob_id_t id1);
        logic [XLEN-1:0] value;
        value         = $random(seed);
        exp_data[id0] = value;
        cdb[0].valid  = 1'b1;
        cdb[0].rob_id = id0;
        cdb[0].data   = value;
        cdb[0].ctrl   = ctrl0;
        if (both) begin
            value         = $random(seed);
            exp_data[id1] = value;
            cdb[1].valid  = 1'b1;
            cdb[1].rob_id = id1;
            cdb[1].data   = value;
            cdb[1].ctrl   = '0;
        end
        next_edge();
        cdb = '0;
    endtask

    task automatic expect_commits(input int n);
        rob_id_t id;
        @(negedge clk);
        for (int i = 0; i < 2; i++) begin
            id = exp_tail + ROB_WIDTH'(i);
            check_value(32'(i < n), 32'(commit[i].valid), $sformatf("commit %0d valid", i));
            if (i < n) begin
                check_value(32'(exp_areg[id]), 32'(commit[i].areg), "commit areg");
                check_value(exp_data[id], commit[i].data, "commit data");
                check_value(exp_pc[id], commit[i].pc, "commit pc");
                check_value(32'(exp_w_reg[id]), 32'(commit[i].w_reg), "commit w_reg");
                check_value(32'(exp_w_mem[id]), 32'(commit[i].w_mem), "commit w_mem");
            end
        end
        next_edge();
        exp_tail = exp_tail + ROB_WIDTH'(n);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_alloc();
        start_test();
        @(negedge clk);
        check_value(32'h1, 32'(dispatch_ready), "dispatch_ready_o after reset");
        check_value(32'h0, 32'(flush), "flush_o after reset");
        check_value(32'h0, 32'(commit[0].valid), "commit 0 valid after reset");
        check_value(32'h0, 32'(commit[1].valid), "commit 1 valid after reset");
        next_edge();
        for (int p = 0; p < 3; p++) begin
            dispatch_pair(32'h0000_1000);
        end
        expect_commits(0);
        end_test("reset and allocation");
    endtask

    task automatic test_in_order_retire();
        start_test();
        // youngest results first
        write_results(6'd5, '0, 1'b1, 6'd4);
        expect_commits(0);
        write_results(6'd3, '0, 1'b1, 6'd2);
        expect_commits(0);
        write_results(6'd1, '0, 1'b1, 6'd0);
        expect_commits(2);
        expect_commits(2);
        expect_commits(2);
        expect_commits(0);
        end_test("in-order retirement");
    endtask

    task automatic test_operand_read();
        rob_id_t older;
        rob_id_t younger;
        start_test();
        older   = exp_head;
        younger = exp_head + 6'd1;
        dispatch_pair(32'h0000_2000);
        write_results(younger, '0, 1'b0, '0);
        dispatch[0].src_id[0] = younger;
        dispatch[0].src_id[1] = older;
        dispatch[1].src_id[0] = older;
        dispatch[1].src_id[1] = younger;
        @(negedge clk);
        check_value(exp_data[younger], disp_reply[0].src_data[0], "slot 0 source 0 data");
        check_value(32'h1, 32'(disp_reply[0].src_ready[0]), "slot 0 source 0 ready");
        check_value(32'h0, 32'(disp_reply[0].src_ready[1]), "slot 0 source 1 ready");
        check_value(32'h0, 32'(disp_reply[1].src_ready[0]), "slot 1 source 0 ready");
        check_value(exp_data[younger], disp_reply[1].src_data[1], "slot 1 source 1 data");
        check_value(32'h1, 32'(disp_reply[1].src_ready[1]), "slot 1 source 1 ready");
        check_value(32'h0, 32'(commit[0].valid), "commit with oldest incomplete");
        next_edge();
        dispatch = '0;
        write_results(older, '0, 1'b0, '0);
        expect_commits(2);
        end_test("operand reads");
    endtask

    task automatic test_full_buffer();
        start_test();
        // fill all 64 entries so the ids wrap past 63
        for (int p = 0; p < ROB_DEPTH / 2; p++) begin
            dispatch_pair(32'h0000_4000);
        end
        @(negedge clk);
        check_value(32'h0, 32'(dispatch_ready), "dispatch_ready_o with full buffer");
        next_edge();
        write_results(exp_tail, '0, 1'b1, exp_tail + 6'd1);
        expect_commits(2);
        dispatch_pair(32'h0000_8000);
        end_test("full buffer");
    endtask

    task automatic test_flush();
        rob_ctrl_t fault;
        rob_id_t   bad_id;
        start_test();
        fault           = '0;
        fault.exception = 1'b1;
        bad_id          = exp_tail;
        write_results(bad_id, fault, 1'b1, bad_id + 6'd1);
        // flagged entry retires alone
        expect_commits(1);
        @(negedge clk);
        check_value(32'h1, 32'(flush), "flush_o after faulting retirement");
        check_value(exp_pc[bad_id], redirect_pc, "redirect_pc_o");
        check_value(32'h0, 32'(dispatch_ready), "dispatch_ready_o during flush");
        check_value(32'h0, 32'(commit[0].valid), "commit during flush");
        next_edge();
        @(negedge clk);
        check_value(32'h0, 32'(flush), "flush_o in resume");
        check_value(32'h0, 32'(dispatch_ready), "dispatch_ready_o in resume");
        next_edge();
        @(negedge clk);
        check_value(32'h1, 32'(dispatch_ready), "dispatch_ready_o after flush");
        check_value(32'h0, 32'(commit[0].valid), "commit from empty buffer");
        next_edge();
        // pointers restart at zero
        exp_head = '0;
        exp_tail = '0;
        dispatch_pair(32'h0000_c000);
        write_results(6'd0, '0, 1'b1, 6'd1);
        expect_commits(2);
        end_test("flush");
    endtask

    initial begin
        seed     = 63;
        rst_n    = 1'b0;
        dispatch = '0;
        cdb      = '0;
        exp_head = '0;
        exp_tail = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_reset_alloc();
        test_in_order_retire();
        test_operand_read();
        test_full_buffer();
        test_flush();

        $display("tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
